/* Makefile */
VERILATOR ?= verilator
TOP ?= dualIssueFrontEnd_tb
RTL_TOP ?= dualIssueFrontEnd
FILELIST ?= dualIssueFrontEnd.f
BUILD_DIR ?= obj_dir
SEED_FLAGS ?= +verilator+seed+1
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SEED_FLAGS) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* dualIssueFrontEnd.f */
source/isaPkg.sv
source/pipePkg.sv
source/fetchPc.sv
source/instFifo.sv
source/instDecoder.sv
source/issueCtrl.sv
source/dualIssueFrontEnd.sv
verification/dualIssueFrontEnd_tb.sv

/* source/dualIssueFrontEnd.sv */
`timescale 1ns/10ps
`default_nettype none

module dualIssueFrontEnd #(
	parameter int unsigned FifoDepth = 8,
	parameter logic [isaPkg::XlenWidth-1:0] ResetPc = '0
) (
	input wire logic clk,
	input wire logic rst_i,
	input wire logic instOk1_i,
	input wire logic instOk2_i,
	input wire isaPkg::instWord_u instRdata1_i,
	input wire isaPkg::instWord_u instRdata2_i,
	input wire logic stall_i,
	output logic instSramEn_o,
	output logic [isaPkg::XlenWidth-1:0] fetchPc_o,
	output pipePkg::issueSlot_t issueMaster_o,
	output pipePkg::issueSlot_t issueSlave_o
);

	logic fifoFull;
	logic fifoEmpty;
	logic fifoOneLeft;
	logic rdMaster;
	logic rdSlave;
	pipePkg::fifoEntry_t headMaster;
	pipePkg::fifoEntry_t headSlave;
	isaPkg::decodedInst_t decMaster;
	isaPkg::decodedInst_t decSlave;

	fetchPc #(
		.ResetPc(ResetPc)
	) i_fetchPc (
		.clk(clk),
		.rst_i(rst_i),
		.fifoFull_i(fifoFull),
		.instOk1_i(instOk1_i),
		.instOk2_i(instOk2_i),
		.instSramEn_o(instSramEn_o),
		.fetchPc_o(fetchPc_o)
	);

	// memory only answers while fetch is enabled
	instFifo #(
		.FifoDepth(FifoDepth)
	) i_instFifo (
		.clk(clk),
		.rst_i(rst_i),
		.wrEn1_i(instOk1_i),
		.wrEn2_i(instOk2_i),
		.wrPc_i(fetchPc_o),
		.wrData1_i(instRdata1_i),
		.wrData2_i(instRdata2_i),
		.rdMaster_i(rdMaster),
		.rdSlave_i(rdSlave),
		.headMaster_o(headMaster),
		.headSlave_o(headSlave),
		.empty_o(fifoEmpty),
		.oneLeft_o(fifoOneLeft),
		.full_o(fifoFull)
	);

	instDecoder i_decMaster (
		.inst_i(headMaster.inst),
		.decoded_o(decMaster)
	);

	instDecoder i_decSlave (
		.inst_i(headSlave.inst),
		.decoded_o(decSlave)
	);

	issueCtrl i_issueCtrl (
		.clk(clk),
		.rst_i(rst_i),
		.stall_i(stall_i),
		.headMaster_i(headMaster),
		.headSlave_i(headSlave),
		.decMaster_i(decMaster),
		.decSlave_i(decSlave),
		.empty_i(fifoEmpty),
		.oneLeft_i(fifoOneLeft),
		.rdMaster_o(rdMaster),
		.rdSlave_o(rdSlave),
		.issueMaster_o(issueMaster_o),
		.issueSlave_o(issueSlave_o)
	);

endmodule

`default_nettype wire

/* source/fetchPc.sv */
`timescale 1ns/10ps
`default_nettype none

module fetchPc #(
	parameter logic [isaPkg::XlenWidth-1:0] ResetPc = '0
) (
	input wire logic clk,
	input wire logic rst_i,
	input wire logic fifoFull_i,
	input wire logic instOk1_i,
	input wire logic instOk2_i,
	output logic instSramEn_o,
	output logic [isaPkg::XlenWidth-1:0] fetchPc_o
);

	// fetch only while the buffer can take a full pair
	assign instSramEn_o = ~fifoFull_i;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			fetchPc_o <= ResetPc;
		end else if (instSramEn_o && instOk1_i) begin
			// skip one or two words
			fetchPc_o <= fetchPc_o + (instOk2_i ? 32'd8 : 32'd4);
		end
	end

	// second word may only come along with the first
	assert property (@(posedge clk) disable iff (rst_i)
		instOk2_i |-> instOk1_i);

endmodule

`default_nettype wire

/* source/instDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

module instDecoder (
	input wire isaPkg::instWord_u inst_i,
	output isaPkg::decodedInst_t decoded_o
);

	always_comb begin
		decoded_o = '0;
		decoded_o.instClass = isaPkg::ClassUndef;
		decoded_o.rs = inst_i.r.rs;
		decoded_o.rt = inst_i.r.rt;
		case (inst_i.r.op)
			isaPkg::OpSpecial: begin
				case (inst_i.r.funct)
					isaPkg::FunctAddu, isaPkg::FunctSubu, isaPkg::FunctAnd,
					isaPkg::FunctOr, isaPkg::FunctSlt: begin
						decoded_o.instClass = isaPkg::ClassAlu;
						decoded_o.dest = inst_i.r.rd;
						decoded_o.wrEn = 1'b1;
						decoded_o.rsUsed = 1'b1;
						decoded_o.rtUsed = 1'b1;
					end
					// result goes to HI/LO, not the register file
					isaPkg::FunctMult: begin
						decoded_o.instClass = isaPkg::ClassHilo;
						decoded_o.rsUsed = 1'b1;
						decoded_o.rtUsed = 1'b1;
					end
					isaPkg::FunctMfhi, isaPkg::FunctMflo: begin
						decoded_o.instClass = isaPkg::ClassHilo;
						decoded_o.dest = inst_i.r.rd;
						decoded_o.wrEn = 1'b1;
					end
					isaPkg::FunctSyscall: begin
						decoded_o.instClass = isaPkg::ClassPriv;
					end
					default: begin
						decoded_o.instClass = isaPkg::ClassUndef;
					end
				endcase
			end
			isaPkg::OpAddiu, isaPkg::OpOri: begin
				decoded_o.instClass = isaPkg::ClassAlu;
				decoded_o.rs = inst_i.i.rs;
				decoded_o.dest = inst_i.i.rt;
				decoded_o.wrEn = 1'b1;
				decoded_o.rsUsed = 1'b1;
			end
			isaPkg::OpLui: begin
				decoded_o.instClass = isaPkg::ClassAlu;
				decoded_o.dest = inst_i.i.rt;
				decoded_o.wrEn = 1'b1;
			end
			isaPkg::OpLw: begin
				decoded_o.instClass = isaPkg::ClassLoad;
				decoded_o.rs = inst_i.i.rs;
				decoded_o.dest = inst_i.i.rt;
				decoded_o.wrEn = 1'b1;
				decoded_o.rsUsed = 1'b1;
			end
			isaPkg::OpSw, isaPkg::OpBeq, isaPkg::OpBne: begin
				decoded_o.instClass = (inst_i.i.op == isaPkg::OpSw) ?
					isaPkg::ClassStore : isaPkg::ClassBranch;
				decoded_o.rs = inst_i.i.rs;
				decoded_o.rt = inst_i.i.rt;
				decoded_o.rsUsed = 1'b1;
				decoded_o.rtUsed = 1'b1;
			end
			isaPkg::OpJ: begin
				decoded_o.instClass = isaPkg::ClassJump;
			end
			isaPkg::OpJal: begin
				decoded_o.instClass = isaPkg::ClassJump;
				// link register r31
				decoded_o.dest = '1;
				decoded_o.wrEn = 1'b1;
			end
			isaPkg::OpCop0: begin
				if (inst_i.r.rs == isaPkg::Cop0Mt) begin
					decoded_o.instClass = isaPkg::ClassPriv;
					decoded_o.rtUsed = 1'b1;
				end else if (inst_i.r.rs == isaPkg::Cop0Co &&
						inst_i.r.funct == isaPkg::FunctEret) begin
					decoded_o.instClass = isaPkg::ClassPriv;
				end
			end
			default: begin
				decoded_o.instClass = isaPkg::ClassUndef;
			end
		endcase
	end

endmodule

`default_nettype wire

/* source/instFifo.sv */
`timescale 1ns/10ps
`default_nettype none

module instFifo #(
	parameter int unsigned FifoDepth = 8
) (
	input wire logic clk,
	input wire logic rst_i,
	input wire logic wrEn1_i,
	input wire logic wrEn2_i,
	input wire logic [isaPkg::XlenWidth-1:0] wrPc_i,
	input wire isaPkg::instWord_u wrData1_i,
	input wire isaPkg::instWord_u wrData2_i,
	input wire logic rdMaster_i,
	input wire logic rdSlave_i,
	output pipePkg::fifoEntry_t headMaster_o,
	output pipePkg::fifoEntry_t headSlave_o,
	output logic empty_o,
	output logic oneLeft_o,
	output logic full_o
);

	localparam int PtrWidth = $clog2(FifoDepth);
	localparam int CntWidth = PtrWidth + 1;

	pipePkg::fifoEntry_t mem [FifoDepth];
	logic [PtrWidth-1:0] head;
	logic [PtrWidth-1:0] tail;
	logic [CntWidth-1:0] count;
	logic [1:0] wrCount;
	logic [1:0] rdCount;

	assign wrCount = {1'b0, wrEn1_i} + {1'b0, wrEn2_i};
	assign rdCount = {1'b0, rdMaster_i} + {1'b0, rdSlave_i};

	always_ff @(posedge clk) begin
		if (wrEn1_i) begin
			mem[tail] <= '{pc: wrPc_i, inst: wrData1_i};
		end
		// second word lives one word after the first
		if (wrEn2_i) begin
			mem[tail + PtrWidth'(1)] <= '{pc: wrPc_i + 32'd4, inst: wrData2_i};
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			head <= head + PtrWidth'(rdCount);
			tail <= tail + PtrWidth'(wrCount);
			count <= count + CntWidth'(wrCount) - CntWidth'(rdCount);
		end
	end

	// two oldest entries, slave is only meaningful with two or more
	assign headMaster_o = mem[head];
	assign headSlave_o = mem[head + PtrWidth'(1)];

	assign empty_o = (count == '0);
	assign oneLeft_o = (count == CntWidth'(1));
	// full means no room for a whole pair
	assign full_o = (count > CntWidth'(FifoDepth - 2));

	assert property (@(posedge clk) disable iff (rst_i)
		wrEn1_i |-> !full_o);

	assert property (@(posedge clk) disable iff (rst_i)
		(rdSlave_i |-> rdMaster_i) and (CntWidth'(rdCount) <= count));

endmodule

`default_nettype wire

/* source/isaPkg.sv */
`default_nettype none

package isaPkg;

	localparam int RegAddrWidth = 5;
	localparam int XlenWidth = 32;

	// R-format view
	typedef struct packed {
		logic [5:0] op;
		logic [RegAddrWidth-1:0] rs;
		logic [RegAddrWidth-1:0] rt;
		logic [RegAddrWidth-1:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rType_t;

	// I-format view
	typedef struct packed {
		logic [5:0] op;
		logic [RegAddrWidth-1:0] rs;
		logic [RegAddrWidth-1:0] rt;
		logic [15:0] imm;
	} iType_t;

	// one fetched word, decoded as R or I format by opcode
	typedef union packed {
		rType_t r;
		iType_t i;
	} instWord_u;

	typedef enum logic [2:0] {
		ClassAlu,
		ClassLoad,
		ClassStore,
		ClassBranch,
		ClassJump,
		ClassHilo,
		ClassPriv,
		ClassUndef
	} instClass_e;

	typedef struct packed {
		instClass_e instClass;
		logic [RegAddrWidth-1:0] dest;
		logic wrEn;
		logic [RegAddrWidth-1:0] rs;
		logic rsUsed;
		logic [RegAddrWidth-1:0] rt;
		logic rtUsed;
	} decodedInst_t;

	// primary opcodes
	localparam logic [5:0] OpSpecial = 6'h00;
	localparam logic [5:0] OpJ = 6'h02;
	localparam logic [5:0] OpJal = 6'h03;
	localparam logic [5:0] OpBeq = 6'h04;
	localparam logic [5:0] OpBne = 6'h05;
	localparam logic [5:0] OpAddiu = 6'h09;
	localparam logic [5:0] OpOri = 6'h0d;
	localparam logic [5:0] OpLui = 6'h0f;
	localparam logic [5:0] OpCop0 = 6'h10;
	localparam logic [5:0] OpLw = 6'h23;
	localparam logic [5:0] OpSw = 6'h2b;

	// SPECIAL funct codes
	localparam logic [5:0] FunctSyscall = 6'h0c;
	localparam logic [5:0] FunctMfhi = 6'h10;
	localparam logic [5:0] FunctMflo = 6'h12;
	localparam logic [5:0] FunctMult = 6'h18;
	localparam logic [5:0] FunctAddu = 6'h21;
	localparam logic [5:0] FunctSubu = 6'h23;
	localparam logic [5:0] FunctAnd = 6'h24;
	localparam logic [5:0] FunctOr = 6'h25;
	localparam logic [5:0] FunctSlt = 6'h2a;

	// COP0 rs field selects, eret sits under CO
	localparam logic [RegAddrWidth-1:0] Cop0Mt = 5'b00100;
	localparam logic [RegAddrWidth-1:0] Cop0Co = 5'b10000;
	localparam logic [5:0] FunctEret = 6'h18;

endpackage

`default_nettype wire

/* source/issueCtrl.sv */
`timescale 1ns/10ps
`default_nettype none

module issueCtrl (
	input wire logic clk,
	input wire logic rst_i,
	input wire logic stall_i,
	input wire pipePkg::fifoEntry_t headMaster_i,
	input wire pipePkg::fifoEntry_t headSlave_i,
	input wire isaPkg::decodedInst_t decMaster_i,
	input wire isaPkg::decodedInst_t decSlave_i,
	input wire logic empty_i,
	input wire logic oneLeft_i,
	output logic rdMaster_o,
	output logic rdSlave_o,
	output pipePkg::issueSlot_t issueMaster_o,
	output pipePkg::issueSlot_t issueSlave_o
);

	logic masterValidQ;
	logic slaveValidQ;
	pipePkg::fifoEntry_t masterEntryQ;
	pipePkg::fifoEntry_t slaveEntryQ;
	isaPkg::decodedInst_t masterDecQ;
	isaPkg::decodedInst_t slaveDecQ;
	logic eitherSerial;
	logic slaveFlow;
	logic slaveMem;
	logic bothHilo;
	logic rawHazard;

	// priv and undefined words always go out alone
	assign eitherSerial =
		decMaster_i.instClass inside {isaPkg::ClassPriv, isaPkg::ClassUndef} ||
		decSlave_i.instClass inside {isaPkg::ClassPriv, isaPkg::ClassUndef};
	assign slaveFlow = decSlave_i.instClass inside {isaPkg::ClassBranch, isaPkg::ClassJump};
	assign slaveMem = decSlave_i.instClass inside {isaPkg::ClassLoad, isaPkg::ClassStore};
	assign bothHilo = (decMaster_i.instClass == isaPkg::ClassHilo) &&
		(decSlave_i.instClass == isaPkg::ClassHilo);

	// slave reads what master writes in the same bundle
	assign rawHazard = decMaster_i.wrEn && (decMaster_i.dest != '0) &&
		((decSlave_i.rsUsed && decSlave_i.rs == decMaster_i.dest) ||
		(decSlave_i.rtUsed && decSlave_i.rt == decMaster_i.dest));

	assign rdMaster_o = !stall_i && !empty_i;
	assign rdSlave_o = rdMaster_o && !oneLeft_i && !eitherSerial && !slaveFlow &&
		!slaveMem && !bothHilo && !rawHazard;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			masterValidQ <= 1'b0;
			slaveValidQ <= 1'b0;
		end else if (!stall_i) begin
			masterValidQ <= rdMaster_o;
			slaveValidQ <= rdSlave_o;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_i) begin
			masterEntryQ <= headMaster_i;
			slaveEntryQ <= headSlave_i;
			masterDecQ <= decMaster_i;
			slaveDecQ <= decSlave_i;
		end
	end

	assign issueMaster_o = '{valid: masterValidQ, pc: masterEntryQ.pc,
		inst: masterEntryQ.inst, dec: masterDecQ};
	assign issueSlave_o = '{valid: slaveValidQ, pc: slaveEntryQ.pc,
		inst: slaveEntryQ.inst, dec: slaveDecQ};

	// slave is the word right after master in program order
	assert property (@(posedge clk) disable iff (rst_i)
		issueSlave_o.valid |-> issueMaster_o.valid &&
		issueSlave_o.pc == issueMaster_o.pc + 32'd4);

endmodule

`default_nettype wire

/* source/pipePkg.sv */
`default_nettype none

package pipePkg;

	// one buffered instruction with its fetch address
	typedef struct packed {
		logic [isaPkg::XlenWidth-1:0] pc;
		isaPkg::instWord_u inst;
	} fifoEntry_t;

	// one lane of the registered issue bundle
	typedef struct packed {
		logic valid;
		logic [isaPkg::XlenWidth-1:0] pc;
		isaPkg::instWord_u inst;
		isaPkg::decodedInst_t dec;
	} issueSlot_t;

endpackage

`default_nettype wire

/* verification/dualIssueFrontEnd_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module dualIssueFrontEnd_tb;

	localparam int ProgWords = 64;
	localparam logic [31:0] ProgBytes = 32'd256;
	localparam int TimeoutCycles = 2000;
	localparam int LongStall = 20;

	typedef struct packed {
		isaPkg::instClass_e cls;
		logic [4:0] dest;
		logic wrEn;
		logic readsRs;
		logic readsRt;
	} refInfo_t;

	logic clk = 1'b0;
	logic rst_i = 1'b1;
	logic instOk1_i = 1'b0;
	logic instOk2_i = 1'b0;
	isaPkg::instWord_u instRdata1_i = '0;
	isaPkg::instWord_u instRdata2_i = '0;
	logic stall_i = 1'b0;
	logic instSramEn_o;
	logic [31:0] fetchPc_o;
	pipePkg::issueSlot_t issueMaster_o;
	pipePkg::issueSlot_t issueSlave_o;

	isaPkg::instWord_u progMem [ProgWords];
	int progLen = 0;
	integer seed = 32'h6cab12c5;
	logic [31:0] stimRand;
	int resetLeft = 5;
	int stallLeft = 0;
	int cycleCount = 0;
	int stallRun = 0;
	logic longRelease = 1'b0;
	logic stallSeen = 1'b0;
	logic rstSeen = 1'b1;
	logic [31:0] expPc = '0;
	logic done = 1'b0;
	pipePkg::issueSlot_t heldMaster;
	pipePkg::issueSlot_t heldSlave;
	logic [31:0] heldFetchPc;

	dualIssueFrontEnd #(
		.FifoDepth(8),
		.ResetPc(32'h0)
	) i_dualIssueFrontEnd (
		.clk(clk),
		.rst_i(rst_i),
		.instOk1_i(instOk1_i),
		.instOk2_i(instOk2_i),
		.instRdata1_i(instRdata1_i),
		.instRdata2_i(instRdata2_i),
		.stall_i(stall_i),
		.instSramEn_o(instSramEn_o),
		.fetchPc_o(fetchPc_o),
		.issueMaster_o(issueMaster_o),
		.issueSlave_o(issueSlave_o)
	);

	always #4 clk = ~clk;

	function automatic isaPkg::instWord_u encR(input logic [5:0] op, input logic [4:0] srcS,
			input logic [4:0] srcT, input logic [4:0] dst, input logic [5:0] fn);
		isaPkg::instWord_u w;
		w.r = '{op: op, rs: srcS, rt: srcT, rd: dst, shamt: 5'd0, funct: fn};
		return w;
	endfunction

	function automatic isaPkg::instWord_u encI(input logic [5:0] op, input logic [4:0] srcS,
			input logic [4:0] srcT, input logic [15:0] imm);
		isaPkg::instWord_u w;
		w.i = '{op: op, rs: srcS, rt: srcT, imm: imm};
		return w;
	endfunction

	// expected class, destination and source reads of one word
	function automatic refInfo_t refDecode(input isaPkg::instWord_u w);
		refInfo_t d;
		d = '{isaPkg::ClassUndef, 5'd0, 1'b0, 1'b0, 1'b0};
		case (w.r.op)
			isaPkg::OpSpecial: begin
				if (w.r.funct inside {isaPkg::FunctAddu, isaPkg::FunctSubu, isaPkg::FunctAnd,
						isaPkg::FunctOr, isaPkg::FunctSlt}) begin
					d = '{isaPkg::ClassAlu, w.r.rd, 1'b1, 1'b1, 1'b1};
				end else if (w.r.funct == isaPkg::FunctMult) begin
					d = '{isaPkg::ClassHilo, 5'd0, 1'b0, 1'b1, 1'b1};
				end else if (w.r.funct inside {isaPkg::FunctMfhi, isaPkg::FunctMflo}) begin
					d = '{isaPkg::ClassHilo, w.r.rd, 1'b1, 1'b0, 1'b0};
				end else if (w.r.funct == isaPkg::FunctSyscall) begin
					d.cls = isaPkg::ClassPriv;
				end
			end
			isaPkg::OpAddiu, isaPkg::OpOri: d = '{isaPkg::ClassAlu, w.i.rt, 1'b1, 1'b1, 1'b0};
			isaPkg::OpLui: d = '{isaPkg::ClassAlu, w.i.rt, 1'b1, 1'b0, 1'b0};
			isaPkg::OpLw: d = '{isaPkg::ClassLoad, w.i.rt, 1'b1, 1'b1, 1'b0};
			isaPkg::OpSw: d = '{isaPkg::ClassStore, 5'd0, 1'b0, 1'b1, 1'b1};
			isaPkg::OpBeq, isaPkg::OpBne: d = '{isaPkg::ClassBranch, 5'd0, 1'b0, 1'b1, 1'b1};
			isaPkg::OpJ: d.cls = isaPkg::ClassJump;
			isaPkg::OpJal: d = '{isaPkg::ClassJump, 5'd31, 1'b1, 1'b0, 1'b0};
			isaPkg::OpCop0: begin
				// mtc0 reads rt and eret needs the CO select with its funct
				if (w.r.rs == 5'd4) begin
					d = '{isaPkg::ClassPriv, 5'd0, 1'b0, 1'b0, 1'b1};
				end else if (w.r.rs == 5'd16 && w.r.funct == 6'h18) begin
					d.cls = isaPkg::ClassPriv;
				end
			end
			default: d.cls = isaPkg::ClassUndef;
		endcase
		return d;
	endfunction

	function automatic logic pairLegal(input isaPkg::instWord_u m, input isaPkg::instWord_u s);
		refInfo_t md;
		refInfo_t sd;
		logic legal;
		md = refDecode(m);
		sd = refDecode(s);
		legal = 1'b1;
		if (md.cls inside {isaPkg::ClassPriv, isaPkg::ClassUndef} ||
				sd.cls inside {isaPkg::ClassPriv, isaPkg::ClassUndef}) begin
			legal = 1'b0;
		end
		if (sd.cls inside {isaPkg::ClassBranch, isaPkg::ClassJump, isaPkg::ClassLoad,
				isaPkg::ClassStore}) begin
			legal = 1'b0;
		end
		if (md.cls == isaPkg::ClassHilo && sd.cls == isaPkg::ClassHilo) begin
			legal = 1'b0;
		end
		if (md.wrEn && md.dest != 5'd0 && ((sd.readsRs && s.r.rs == md.dest) ||
				(sd.readsRt && s.r.rt == md.dest))) begin
			legal = 1'b0;
		end
		return legal;
	endfunction

	task automatic put(input isaPkg::instWord_u w);
		progMem[progLen] = w;
		progLen = progLen + 1;
	endtask

	task automatic buildProgram();
		logic [31:0] r;
		logic [4:0] ra;
		logic [4:0] rb;
		logic [4:0] rc;
		// independent ALU pair and then RAW through rs
		put(encR(isaPkg::OpSpecial, 5'd2, 5'd3, 5'd1, isaPkg::FunctAddu));
		put(encR(isaPkg::OpSpecial, 5'd5, 5'd6, 5'd4, isaPkg::FunctOr));
		put(encI(isaPkg::OpAddiu, 5'd0, 5'd7, 16'd5));
		put(encR(isaPkg::OpSpecial, 5'd7, 5'd1, 5'd8, isaPkg::FunctSubu));
		put(encR(isaPkg::OpSpecial, 5'd1, 5'd2, 5'd0, isaPkg::FunctMult));
		put(encR(isaPkg::OpSpecial, 5'd0, 5'd0, 5'd9, isaPkg::FunctMflo));
		put(encI(isaPkg::OpOri, 5'd0, 5'd10, 16'd1));
		put(encI(isaPkg::OpLw, 5'd10, 5'd11, 16'd0));
		put(encI(isaPkg::OpLui, 5'd0, 5'd12, 16'd1));
		put(encI(isaPkg::OpSw, 5'd0, 5'd12, 16'd4));
		put(encR(isaPkg::OpSpecial, 5'd1, 5'd2, 5'd13, isaPkg::FunctAnd));
		put(encI(isaPkg::OpBeq, 5'd1, 5'd2, 16'd3));
		put(encR(isaPkg::OpSpecial, 5'd1, 5'd2, 5'd14, isaPkg::FunctSlt));
		put(encI(isaPkg::OpJ, 5'd0, 5'd0, 16'h0040));
		put(encR(isaPkg::OpSpecial, 5'd0, 5'd0, 5'd0, isaPkg::FunctSyscall));
		put(encR(isaPkg::OpSpecial, 5'd1, 5'd1, 5'd1, isaPkg::FunctAddu));
		put(encI(isaPkg::OpAddiu, 5'd2, 5'd2, 16'd1));
		put(encR(isaPkg::OpCop0, 5'd4, 5'd2, 5'd12, 6'h00));
		put(32'hfc000000);
		put(encR(isaPkg::OpSpecial, 5'd4, 5'd5, 5'd3, isaPkg::FunctAddu));
		put(encI(isaPkg::OpJal, 5'd0, 5'd0, 16'h0080));
		put(encR(isaPkg::OpSpecial, 5'd31, 5'd1, 5'd5, isaPkg::FunctAddu));
		put(encR(isaPkg::OpCop0, 5'd16, 5'd0, 5'd0, 6'h18));
		put(encR(isaPkg::OpSpecial, 5'd1, 5'd2, 5'd3, 6'h3f));
		// writes to r0 never block the slave
		put(encR(isaPkg::OpSpecial, 5'd1, 5'd2, 5'd0, isaPkg::FunctAddu));
		put(encR(isaPkg::OpSpecial, 5'd0, 5'd0, 5'd3, isaPkg::FunctOr));
		// rest is random over a small register range
		while (progLen < ProgWords) begin
			r = $random(seed);
			ra = {2'b00, r[10:8]};
			rb = {2'b00, r[13:11]};
			rc = {2'b00, r[16:14]};
			case (r[3:0])
				4'd0, 4'd1, 4'd2: put(encR(isaPkg::OpSpecial, ra, rb, rc, isaPkg::FunctAddu));
				4'd3: put(encR(isaPkg::OpSpecial, ra, rb, rc, isaPkg::FunctSlt));
				4'd4, 4'd5: put(encI(isaPkg::OpAddiu, ra, rb, r[31:16]));
				4'd6: put(encI(isaPkg::OpOri, ra, rb, r[31:16]));
				4'd7: put(encI(isaPkg::OpLw, ra, rb, r[31:16]));
				4'd8: put(encI(isaPkg::OpSw, ra, rb, r[31:16]));
				4'd9: put(encI(isaPkg::OpBne, ra, rb, r[31:16]));
				4'd10: put(encR(isaPkg::OpSpecial, ra, rb, 5'd0, isaPkg::FunctMult));
				4'd11: put(encR(isaPkg::OpSpecial, 5'd0, 5'd0, rc, isaPkg::FunctMfhi));
				4'd12: put(encI(isaPkg::OpLui, 5'd0, rb, r[31:16]));
				4'd13: put(encR(isaPkg::OpSpecial, ra, rb, rc, isaPkg::FunctSubu));
				4'd14: put(encR(isaPkg::OpSpecial, ra, rb, rc, isaPkg::FunctAnd));
				default: put(r);
			endcase
		end
	endtask

	task automatic reportFailure();
		$display("Testbench failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkSlot(input pipePkg::issueSlot_t slot, input string lane);
		refInfo_t e;
		isaPkg::instWord_u w;
		w = progMem[expPc[7:2]];
		e = refDecode(w);
		assert (slot.pc == expPc) else begin
			$display("Fail at %0t ns: %s pc %h, expected %h", $time, lane, slot.pc, expPc);
			reportFailure();
		end
		assert (slot.inst == w) else begin
			$display("Fail at %0t ns: %s word %h, expected %h", $time, lane, slot.inst, w);
			reportFailure();
		end
		assert (slot.dec.instClass == e.cls && slot.dec.wrEn == e.wrEn &&
				slot.dec.dest == e.dest) else begin
			$display("Fail at %0t ns: %s decode of %h is %s r%0d we %b, expected %s r%0d we %b",
				$time, lane, w, slot.dec.instClass.name(), slot.dec.dest, slot.dec.wrEn,
				e.cls.name(), e.dest, e.wrEn);
			reportFailure();
		end
		assert (slot.dec.rsUsed == e.readsRs && slot.dec.rtUsed == e.readsRt &&
				(!e.readsRs || slot.dec.rs == w.r.rs) &&
				(!e.readsRt || slot.dec.rt == w.r.rt)) else begin
			$display("Fail at %0t ns: %s sources of %h are rs %b r%0d rt %b r%0d",
				$time, lane, w, slot.dec.rsUsed, slot.dec.rs, slot.dec.rtUsed, slot.dec.rt);
			$display("expected rs %b r%0d rt %b r%0d", e.readsRs, w.r.rs, e.readsRt, w.r.rt);
			reportFailure();
		end
		expPc = expPc + 32'd4;
	endtask

	// stimulus on the falling edge
	always @(negedge clk) begin
		stimRand = $random(seed);
		if (resetLeft > 1) begin
			resetLeft = resetLeft - 1;
		end else begin
			rst_i = 1'b0;
		end
		if (!rst_i && instSramEn_o && fetchPc_o < ProgBytes) begin
			instOk1_i = (stimRand[1:0] != 2'b00);
			instOk2_i = instOk1_i && stimRand[2] && (fetchPc_o + 32'd4 < ProgBytes);
		end else begin
			instOk1_i = 1'b0;
			instOk2_i = 1'b0;
		end
		instRdata1_i = progMem[fetchPc_o[7:2]];
		instRdata2_i = progMem[fetchPc_o[7:2] + 6'd1];
		if (stallLeft > 0) begin
			stall_i = 1'b1;
			stallLeft = stallLeft - 1;
		end else if (!rst_i && (cycleCount == 20 || stimRand[9:4] == 6'd0)) begin
			// long stall so the FIFO fills up
			stall_i = 1'b1;
			stallLeft = LongStall + 3;
		end else begin
			stall_i = !rst_i && (stimRand[12:11] == 2'b00);
		end
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		stallSeen <= stall_i;
		rstSeen <= rst_i;
		stallRun <= (rst_i || !stall_i) ? 0 : stallRun + 1;
		longRelease <= !rst_i && !stall_i && stallRun >= LongStall;
	end

	// compares the registered bundle between edges
	always @(negedge clk) begin
		if (!rstSeen) begin
			if (stallSeen) begin
				assert (issueMaster_o === heldMaster && issueSlave_o === heldSlave) else begin
					$display("Fail at %0t ns: issue bundle changed during stall", $time);
					reportFailure();
				end
			end else begin
				if (longRelease && expPc < ProgBytes) begin
					assert (issueMaster_o.valid) else begin
						$display("Fail at %0t ns: no issue after a long stall", $time);
						reportFailure();
					end
					if (expPc + 32'd4 < ProgBytes &&
							pairLegal(progMem[expPc[7:2]], progMem[expPc[7:2] + 6'd1])) begin
						assert (issueSlave_o.valid) else begin
							$display("Fail at %0t ns: legal pair at %h single-issued", $time, expPc);
							reportFailure();
						end
					end
				end
				if (issueMaster_o.valid) begin
					checkSlot(issueMaster_o, "master");
				end
				if (issueSlave_o.valid) begin
					assert (issueMaster_o.valid) else begin
						$display("Fail at %0t ns: slave valid without master", $time);
						reportFailure();
					end
					checkSlot(issueSlave_o, "slave");
					assert (pairLegal(issueMaster_o.inst, issueSlave_o.inst)) else begin
						$display("Fail at %0t ns: illegal pair %h %h issued", $time,
							issueMaster_o.inst, issueSlave_o.inst);
						reportFailure();
					end
				end
			end
			// back-pressure once the FIFO had time to fill
			if (stallRun >= LongStall && fetchPc_o < ProgBytes) begin
				assert (!instSramEn_o) else begin
					$display("Fail at %0t ns: fetch still enabled in a long stall", $time);
					reportFailure();
				end
				if (stallRun > LongStall) begin
					assert (fetchPc_o == heldFetchPc) else begin
						$display("Fail at %0t ns: fetch pc moved to %h", $time, fetchPc_o);
						reportFailure();
					end
				end
			end
			if (expPc == ProgBytes) begin
				done = 1'b1;
			end
		end
		heldMaster = issueMaster_o;
		heldSlave = issueSlave_o;
		heldFetchPc = fetchPc_o;
	end

	initial begin
		buildProgram();
		while (!done && cycleCount < TimeoutCycles) begin
			@(posedge clk);
		end
		if (done) begin
			$display("Testbench passed");
			$finish;
		end else begin
			$display("Testbench failed");
			$fatal(1, "timeout, issue did not finish within %0d cycles", TimeoutCycles);
		end
	end

endmodule

`default_nettype wire
